/* all.f */
hw/axi_lite_pkg.sv
hw/nes_regs_pkg.sv
hw/reg_access_if.sv
hw/axi_lite_slave.sv
hw/nes_reg_bank.sv
hw/nes_axi_regs.sv
bench/nes_axi_regs_assert.sv
bench/tb_nes_axi_regs.sv

/* bench/nes_axi_regs_assert.sv */
/*
  Concurrent checks on the AXI-Lite handshakes and the HCI strobes.
  Bound into nes_axi_regs; failure counts are read by the testbench.
*/
`timescale 1ns/1ps

module nes_axi_regs_assert (
  input logic                    clk,
  input logic                    w_axi_rst,
  input logic                    o_awready,
  input logic                    o_bvalid,
  input logic                    i_bready,
  input axi_lite_pkg::axi_resp_e o_bresp,
  input logic                    o_rvalid,
  input logic                    i_rready,
  input axi_lite_pkg::axi_resp_e o_rresp,
  input axi_lite_pkg::axi_data_t o_rdata,
  input logic                    o_hci_opcode_stb,
  input logic                    o_hci_din_stb,
  input logic                    o_hci_host_ready
);
  int bvalid_fails = 0;
  int rvalid_fails = 0;
  int awready_fails = 0;
  int opcode_fails = 0;
  int din_fails = 0;
  int ready_fails = 0;
  int fail_count;

  assign fail_count = bvalid_fails + rvalid_fails + awready_fails
                    + opcode_fails + din_fails + ready_fails;

  // Write response must wait for the master
  bvalid_held: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else begin
      bvalid_fails++;
      $error("bvalid dropped or bresp changed before bready");
    end

  rvalid_held: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rresp) && $stable(o_rdata))
    else begin
      rvalid_fails++;
      $error("rvalid dropped or read data changed before rready");
    end

  awready_pulse: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_awready |=> !o_awready)
    else begin
      awready_fails++;
      $error("awready held longer than one cycle");
    end

  // HCI strobes are single-cycle pulses
  opcode_stb_pulse: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_hci_opcode_stb |=> !o_hci_opcode_stb)
    else begin
      opcode_fails++;
      $error("opcode strobe longer than one cycle");
    end

  din_stb_pulse: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_hci_din_stb |=> !o_hci_din_stb)
    else begin
      din_fails++;
      $error("din strobe longer than one cycle");
    end

  host_ready_pulse: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_hci_host_ready |=> !o_hci_host_ready)
    else begin
      ready_fails++;
      $error("host ready longer than one cycle");
    end

endmodule

bind nes_axi_regs nes_axi_regs_assert nes_axi_regs_assert_inst (
  .clk              (clk),
  .w_axi_rst        (w_axi_rst),
  .o_awready        (o_awready),
  .o_bvalid         (o_bvalid),
  .i_bready         (i_bready),
  .o_bresp          (o_bresp),
  .o_rvalid         (o_rvalid),
  .i_rready         (i_rready),
  .o_rresp          (o_rresp),
  .o_rdata          (o_rdata),
  .o_hci_opcode_stb (o_hci_opcode_stb),
  .o_hci_din_stb    (o_hci_din_stb),
  .o_hci_host_ready (o_hci_host_ready)
);

/* bench/nes_axi_regs_testdata.txt */
# kind, byte address, data, expected response (0 OKAY, 2 SLVERR), expected data, all hex
# write: expected is the side port value (opcode, din, {jp2,jp1}) or host ready pulses
# hci_ack: data bit 16 is the ready level, bits 15..0 the status
read     00  00000000  0  00000003
read     0c  00000000  0  00000000
read     10  00000000  0  00000000
write    00  fffffffe  0  00000000
read     00  00000000  0  00000002
write    0c  deadbeef  0  00000000
read     0c  00000000  0  deadbeef
write    10  12345678  0  00000000
read     10  00000000  0  00005678
write    14  000001a5  0  000000a5
read     14  00000000  0  000000a5
write    08  0000c35a  0  0000c35a
write    18  000012e7  0  000000e7
write    1c  00000001  0  00000001
write    1c  00000000  0  00000000
hci_ack  00  0001beef  0  00000000
read     04  00000000  0  beef0002
hci_ack  00  00001234  0  00000000
read     04  00000000  0  12340000
hci_dout 00  0000003c  0  00000000
read     18  00000000  0  0000003c
read     2c  00000000  0  10000000
read     28  00000000  0  00000000
read     30  00000000  2  00000000
write    30  ffffffff  2  00000000
write    fc  00000003  2  00000000
read     fc  00000000  2  00000000
read     00  00000000  0  00000002
read     0c  00000000  0  deadbeef
read     14  00000000  0  000000a5

/* bench/tb_nes_axi_regs.sv */
/*
  Testbench for the console register endpoint. Steps come from the test
  data file; AXI responses, side ports and strobe counts are checked.
*/
`timescale 1ns/1ps

module tb_nes_axi_regs;
  import axi_lite_pkg::*;
  import nes_regs_pkg::*;

  localparam int WAIT_LIMIT = 50;
  localparam int SEED       = 85003;

  logic        clk;
  logic        w_axi_rst;
  logic        i_awvalid;
  axi_addr_t   i_awaddr;
  logic        o_awready;
  logic        i_wvalid;
  axi_data_t   i_wdata;
  logic        o_wready;
  logic        o_bvalid;
  logic        i_bready;
  axi_resp_e   o_bresp;
  logic        i_arvalid;
  axi_addr_t   i_araddr;
  logic        o_arready;
  logic        o_rvalid;
  logic        i_rready;
  axi_resp_e   o_rresp;
  axi_data_t   o_rdata;
  logic        o_hci_reset;
  logic        o_console_reset;
  logic [7:0]  o_jp1_state;
  logic [7:0]  o_jp2_state;
  hci_opcode_t o_hci_opcode;
  logic        o_hci_opcode_stb;
  hci_byte_t   o_hci_din;
  logic        o_hci_din_stb;
  logic        o_hci_host_ready;
  hci_addr_t   o_hci_addr;
  axi_data_t   o_hci_count;
  logic        i_hci_sm_ready;
  logic        i_hci_opcode_ack;
  hci_status_t i_hci_opcode_status;
  logic        i_hci_dout_stb;
  hci_byte_t   i_hci_dout;

  int   errors = 0;
  int   test_errors = 0;
  int   tests = 0;
  logic timeout_hit = 1'b0;
  // Running totals of each strobe, only ever incremented
  int   opcode_pulses = 0;
  int   din_pulses = 0;
  int   ready_pulses = 0;

  nes_axi_regs nes_axi_regs_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (o_hci_opcode_stb) opcode_pulses++;
    if (o_hci_din_stb) din_pulses++;
    if (o_hci_host_ready) ready_pulses++;
  end

  task automatic report_timeout(input string what);
    $display("timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
    timeout_hit = 1'b1;
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_hci_byte(input string name, input hci_byte_t got, input hci_byte_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_hci_addr(input string name, input hci_addr_t got, input hci_addr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%04h expected 0x%04h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch %s pulses: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                           output axi_resp_e resp);
    int cycles;
    int delay;
    delay = $urandom % 4;
    @(posedge clk);
    i_awvalid <= 1'b1;
    i_awaddr  <= addr;
    i_wvalid  <= 1'b1;
    i_wdata   <= data;
    cycles = 0;
    @(negedge clk);
    while (!(o_awready && o_wready)) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("awready and wready");
        return;
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!o_bvalid) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("bvalid");
        return;
      end
      cycles++;
      @(negedge clk);
    end
    // Hold off bready to exercise back-pressure
    repeat (delay) @(posedge clk);
    @(negedge clk);
    resp = o_bresp;
    @(posedge clk);
    i_bready <= 1'b1;
    @(posedge clk);
    i_bready <= 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_resp_e resp,
                          output axi_data_t data);
    int cycles;
    int delay;
    delay = $urandom % 4;
    @(posedge clk);
    i_arvalid <= 1'b1;
    i_araddr  <= addr;
    cycles = 0;
    @(negedge clk);
    while (!o_arready) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("arready");
        return;
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    i_arvalid <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!o_rvalid) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("rvalid");
        return;
      end
      cycles++;
      @(negedge clk);
    end
    repeat (delay) @(posedge clk);
    @(negedge clk);
    resp = o_rresp;
    data = o_rdata;
    @(posedge clk);
    i_rready <= 1'b1;
    @(posedge clk);
    i_rready <= 1'b0;
  endtask

  // Status in bits 15..0, ready level in bit 16
  task automatic drive_hci_ack(input axi_data_t word);
    @(posedge clk);
    i_hci_sm_ready      <= word[16];
    i_hci_opcode_status <= word[15:0];
    i_hci_opcode_ack    <= 1'b1;
    @(posedge clk);
    i_hci_opcode_ack    <= 1'b0;
  endtask

  task automatic drive_hci_dout(input hci_byte_t value);
    @(posedge clk);
    i_hci_dout     <= value;
    i_hci_dout_stb <= 1'b1;
    @(posedge clk);
    i_hci_dout_stb <= 1'b0;
  endtask

  task automatic run_step(input string kind, input axi_data_t addr_word,
                          input axi_data_t data_word, input axi_data_t resp_word,
                          input axi_data_t exp_word);
    axi_resp_e got_resp;
    axi_data_t got_data;
    logic [REG_INDEX_W-1:0] index;
    int opcode_start;
    int din_start;
    int ready_start;
    index = addr_word[AXI_ADDR_W-1:2];
    test_errors = 0;
    if (kind == "write") begin
      tests++;
      opcode_start = opcode_pulses;
      din_start    = din_pulses;
      ready_start  = ready_pulses;
      axi_write(addr_word[AXI_ADDR_W-1:0], data_word, got_resp);
      if (timeout_hit) return;
      check_resp("bresp", got_resp, axi_resp_e'(resp_word[1:0]));
      check_count("o_hci_opcode_stb", opcode_pulses - opcode_start,
                  (index == HCI_OPCODE) ? 1 : 0);
      check_count("o_hci_din_stb", din_pulses - din_start, (index == HCI_DATA) ? 1 : 0);
      check_count("o_hci_host_ready", ready_pulses - ready_start,
                  (index == HCI_READ_STB) ? int'(exp_word) : 0);
      if (index == HCI_OPCODE) check_hci_byte("o_hci_opcode", o_hci_opcode, exp_word[7:0]);
      if (index == HCI_DATA) check_hci_byte("o_hci_din", o_hci_din, exp_word[7:0]);
      if (index == USER_INPUT) begin
        check_hci_byte("o_jp1_state", o_jp1_state, exp_word[7:0]);
        check_hci_byte("o_jp2_state", o_jp2_state, exp_word[15:8]);
      end
      // Control, count and address ports follow the written word
      if (index == CONTROL) begin
        check_level("o_hci_reset", o_hci_reset, data_word[CTRL_HCI_RESET_BIT]);
        check_level("o_console_reset", o_console_reset, data_word[CTRL_CONSOLE_RESET_BIT]);
      end
      if (index == HCI_COUNT) check_data("o_hci_count", o_hci_count, data_word);
      if (index == HCI_ADDR) check_hci_addr("o_hci_addr", o_hci_addr, data_word[15:0]);
      $display("test %0d: write 0x%02h %s", tests, addr_word[7:0],
               (test_errors == 0) ? "ok" : "FAIL");
    end else if (kind == "read") begin
      tests++;
      axi_read(addr_word[AXI_ADDR_W-1:0], got_resp, got_data);
      if (timeout_hit) return;
      check_resp("rresp", got_resp, axi_resp_e'(resp_word[1:0]));
      check_data("rdata", got_data, exp_word);
      $display("test %0d: read 0x%02h %s", tests, addr_word[7:0],
               (test_errors == 0) ? "ok" : "FAIL");
    end else if (kind == "hci_ack") begin
      drive_hci_ack(data_word);
    end else if (kind == "hci_dout") begin
      drive_hci_dout(data_word[7:0]);
    end else begin
      $display("unknown step kind '%s' in test data", kind);
      errors++;
    end
  endtask

  initial begin
    int        fd;
    int        fields;
    int        assert_fails;
    string     line;
    string     kind;
    axi_data_t addr_word;
    axi_data_t data_word;
    axi_data_t resp_word;
    axi_data_t exp_word;
    void'($urandom(SEED));
    w_axi_rst           <= 1'b1;
    i_awvalid           <= 1'b0;
    i_awaddr            <= '0;
    i_wvalid            <= 1'b0;
    i_wdata             <= '0;
    i_bready            <= 1'b0;
    i_arvalid           <= 1'b0;
    i_araddr            <= '0;
    i_rready            <= 1'b0;
    i_hci_sm_ready      <= 1'b0;
    i_hci_opcode_ack    <= 1'b0;
    i_hci_opcode_status <= '0;
    i_hci_dout_stb      <= 1'b0;
    i_hci_dout          <= '0;
    repeat (5) @(posedge clk);
    w_axi_rst <= 1'b0;

    // Console outputs straight out of reset
    @(negedge clk);
    tests++;
    test_errors = 0;
    check_level("o_hci_reset", o_hci_reset, 1'b1);
    check_level("o_console_reset", o_console_reset, 1'b1);
    check_data("o_hci_count", o_hci_count, '0);
    check_hci_addr("o_hci_addr", o_hci_addr, '0);
    check_hci_byte("o_jp1_state", o_jp1_state, '0);
    check_hci_byte("o_jp2_state", o_jp2_state, '0);
    $display("test %0d: reset outputs %s", tests, (test_errors == 0) ? "ok" : "FAIL");

    fd = $fopen("bench/nes_axi_regs_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      errors++;
    end else begin
      while (!$feof(fd) && !timeout_hit) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line.getc(0) == "#") continue;
        fields = $sscanf(line, "%s %h %h %h %h", kind, addr_word, data_word,
                         resp_word, exp_word);
        if (fields != 5) continue;
        run_step(kind, addr_word, data_word, resp_word, exp_word);
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    assert_fails = nes_axi_regs_inst.nes_axi_regs_assert_inst.fail_count;
    $display("tests %0d, check errors %0d, assertion failures %0d, timeout %0d",
             tests, errors, assert_fails, timeout_hit);
    if (errors == 0 && assert_fails == 0 && !timeout_hit && tests > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* hw/axi_lite_pkg.sv */
/*
  AXI-Lite bus widths, response codes and the slave state type.
  Imported by the register slave, the register bank and the top level.
*/
package axi_lite_pkg;

  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;

  // Only the two responses this slave ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [2:0] {
    IDLE,
    WRITE_REG,
    WRITE_RESP,
    READ_REG,
    READ_RESP
  } slave_state_e;

endpackage

/* hw/axi_lite_slave.sv */
/*
  AXI-Lite slave that turns each bus write or read into one register access
  on reg_access_if, then returns the response once the bank has answered.
*/
`timescale 1ns/1ps

module axi_lite_slave (
  input  logic                      clk,
  input  logic                      w_axi_rst,

  // Write address and data
  input  logic                      i_awvalid,
  input  axi_lite_pkg::axi_addr_t   i_awaddr,
  output logic                      o_awready,
  input  logic                      i_wvalid,
  input  axi_lite_pkg::axi_data_t   i_wdata,
  output logic                      o_wready,

  // Write response
  output logic                      o_bvalid,
  input  logic                      i_bready,
  output axi_lite_pkg::axi_resp_e   o_bresp,

  // Read address and data
  input  logic                      i_arvalid,
  input  axi_lite_pkg::axi_addr_t   i_araddr,
  output logic                      o_arready,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  output axi_lite_pkg::axi_resp_e   o_rresp,
  output axi_lite_pkg::axi_data_t   o_rdata,

  reg_access_if.slave               reg_if
);
  import axi_lite_pkg::*;
  import nes_regs_pkg::*;

  slave_state_e state;
  logic         wr_accept;
  logic         rd_accept;

  // Writes win when both channels are offered in the same cycle
  assign wr_accept = (state == IDLE) && i_awvalid && i_wvalid;
  assign rd_accept = (state == IDLE) && !wr_accept && i_arvalid;

  always_ff @(posedge clk) begin
    o_awready <= 1'b0;
    o_wready  <= 1'b0;
    o_arready <= 1'b0;
    if (w_axi_rst) begin
      state         <= IDLE;
      reg_if.wr_rdy <= 1'b0;
      reg_if.rd_req <= 1'b0;
      o_bvalid      <= 1'b0;
      o_rvalid      <= 1'b0;
      o_bresp       <= OKAY;
      o_rresp       <= OKAY;
    end else begin
      case (state)
        IDLE: begin
          if (wr_accept) begin
            o_awready     <= 1'b1;
            o_wready      <= 1'b1;
            reg_if.wr_rdy <= 1'b1;
            state         <= WRITE_REG;
          end else if (rd_accept) begin
            o_arready     <= 1'b1;
            reg_if.rd_req <= 1'b1;
            state         <= READ_REG;
          end
        end
        WRITE_REG: begin
          if (reg_if.wr_ack) begin
            reg_if.wr_rdy <= 1'b0;
            o_bresp       <= reg_if.invalid ? SLVERR : OKAY;
            o_bvalid      <= 1'b1;
            state         <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          // Response held steady until the master takes it
          if (i_bready) begin
            o_bvalid <= 1'b0;
            state    <= IDLE;
          end
        end
        READ_REG: begin
          if (reg_if.rd_ack) begin
            reg_if.rd_req <= 1'b0;
            o_rresp       <= reg_if.invalid ? SLVERR : OKAY;
            o_rvalid      <= 1'b1;
            state         <= READ_RESP;
          end
        end
        READ_RESP: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, write word and read data
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      reg_if.index   <= reg_index_e'(i_awaddr[AXI_ADDR_W-1:2]);
      reg_if.wr_data <= i_wdata;
    end else if (rd_accept) begin
      reg_if.index   <= reg_index_e'(i_araddr[AXI_ADDR_W-1:2]);
    end
    if (state == READ_REG && reg_if.rd_ack) begin
      o_rdata <= reg_if.rd_data;
    end
  end

endmodule

/* hw/nes_axi_regs.sv */
/*
  Host register endpoint of the console core: AXI-Lite in, console
  controls, joypads and HCI out. All ports are plain signals.
*/
`timescale 1ns/1ps

module nes_axi_regs (
  input  logic                        clk,
  input  logic                        w_axi_rst,

  // AXI-Lite
  input  logic                        i_awvalid,
  input  axi_lite_pkg::axi_addr_t     i_awaddr,
  output logic                        o_awready,
  input  logic                        i_wvalid,
  input  axi_lite_pkg::axi_data_t     i_wdata,
  output logic                        o_wready,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  output axi_lite_pkg::axi_resp_e     o_bresp,
  input  logic                        i_arvalid,
  input  axi_lite_pkg::axi_addr_t     i_araddr,
  output logic                        o_arready,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output axi_lite_pkg::axi_resp_e     o_rresp,
  output axi_lite_pkg::axi_data_t     o_rdata,

  // Console and HCI
  output logic                        o_hci_reset,
  output logic                        o_console_reset,
  output logic [7:0]                  o_jp1_state,
  output logic [7:0]                  o_jp2_state,
  output nes_regs_pkg::hci_opcode_t   o_hci_opcode,
  output logic                        o_hci_opcode_stb,
  output nes_regs_pkg::hci_byte_t     o_hci_din,
  output logic                        o_hci_din_stb,
  output logic                        o_hci_host_ready,
  output nes_regs_pkg::hci_addr_t     o_hci_addr,
  output axi_lite_pkg::axi_data_t     o_hci_count,
  input  logic                        i_hci_sm_ready,
  input  logic                        i_hci_opcode_ack,
  input  nes_regs_pkg::hci_status_t   i_hci_opcode_status,
  input  logic                        i_hci_dout_stb,
  input  nes_regs_pkg::hci_byte_t     i_hci_dout
);

  reg_access_if reg_if ();

  axi_lite_slave axi_lite_slave_inst (
    .clk       (clk),
    .w_axi_rst (w_axi_rst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rresp   (o_rresp),
    .o_rdata   (o_rdata),
    .reg_if    (reg_if.slave)
  );

  nes_reg_bank nes_reg_bank_inst (
    .clk                 (clk),
    .w_axi_rst           (w_axi_rst),
    .reg_if              (reg_if.bank),
    .o_hci_reset         (o_hci_reset),
    .o_console_reset     (o_console_reset),
    .o_jp1_state         (o_jp1_state),
    .o_jp2_state         (o_jp2_state),
    .o_hci_opcode        (o_hci_opcode),
    .o_hci_opcode_stb    (o_hci_opcode_stb),
    .o_hci_din           (o_hci_din),
    .o_hci_din_stb       (o_hci_din_stb),
    .o_hci_host_ready    (o_hci_host_ready),
    .o_hci_addr          (o_hci_addr),
    .o_hci_count         (o_hci_count),
    .i_hci_sm_ready      (i_hci_sm_ready),
    .i_hci_opcode_ack    (i_hci_opcode_ack),
    .i_hci_opcode_status (i_hci_opcode_status),
    .i_hci_dout_stb      (i_hci_dout_stb),
    .i_hci_dout          (i_hci_dout)
  );

endmodule

/* hw/nes_reg_bank.sv */
/*
  Register bank behind the AXI-Lite slave. Decodes register accesses into
  console controls, joypad states and HCI strobes, and builds the readback.
*/
`timescale 1ns/1ps

module nes_reg_bank (
  input  logic                        clk,
  input  logic                        w_axi_rst,

  reg_access_if.bank                  reg_if,

  // Console controls
  output logic                        o_hci_reset,
  output logic                        o_console_reset,
  output logic [7:0]                  o_jp1_state,
  output logic [7:0]                  o_jp2_state,

  // HCI toward the console core
  output nes_regs_pkg::hci_opcode_t   o_hci_opcode,
  output logic                        o_hci_opcode_stb,
  output nes_regs_pkg::hci_byte_t     o_hci_din,
  output logic                        o_hci_din_stb,
  output logic                        o_hci_host_ready,
  output nes_regs_pkg::hci_addr_t     o_hci_addr,
  output axi_lite_pkg::axi_data_t     o_hci_count,

  // HCI results from the console core
  input  logic                        i_hci_sm_ready,
  input  logic                        i_hci_opcode_ack,
  input  nes_regs_pkg::hci_status_t   i_hci_opcode_status,
  input  logic                        i_hci_dout_stb,
  input  nes_regs_pkg::hci_byte_t     i_hci_dout
);
  import axi_lite_pkg::*;
  import nes_regs_pkg::*;

  hci_status_t hci_status;
  hci_byte_t   hci_dout;
  logic        wr_fire;
  logic        rd_fire;
  axi_data_t   read_word;

  // A level seen right after our own ack is the old request
  assign wr_fire = reg_if.wr_rdy && !reg_if.wr_ack;
  assign rd_fire = reg_if.rd_req && !reg_if.rd_ack && !wr_fire;

  always_comb begin
    read_word = '0;
    case (reg_if.index)
      CONTROL: begin
        read_word[CTRL_HCI_RESET_BIT]     = o_hci_reset;
        read_word[CTRL_CONSOLE_RESET_BIT] = o_console_reset;
      end
      STATUS: begin
        read_word[STAT_HCI_READY_BIT]         = i_hci_sm_ready;
        read_word[STAT_HCI_STATUS_LSB +: 16] = hci_status;
      end
      HCI_COUNT:  read_word = o_hci_count;
      HCI_ADDR:   read_word[15:0] = o_hci_addr;
      HCI_OPCODE: read_word[7:0] = o_hci_opcode;
      HCI_DATA:   read_word[7:0] = hci_dout;
      VERSION:    read_word = VERSION_WORD;
      default:    read_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    reg_if.wr_ack    <= 1'b0;
    reg_if.rd_ack    <= 1'b0;
    reg_if.invalid   <= 1'b0;
    o_hci_opcode_stb <= 1'b0;
    o_hci_din_stb    <= 1'b0;
    o_hci_host_ready <= 1'b0;
    if (w_axi_rst) begin
      o_hci_reset     <= 1'b1;
      o_console_reset <= 1'b1;
      o_jp1_state     <= '0;
      o_jp2_state     <= '0;
      o_hci_opcode    <= '0;
      o_hci_din       <= '0;
      o_hci_addr      <= '0;
      o_hci_count     <= '0;
      hci_status      <= '0;
      hci_dout        <= '0;
    end else begin
      // Console results are captured whenever they arrive
      if (i_hci_opcode_ack) begin
        hci_status <= i_hci_opcode_status;
      end
      if (i_hci_dout_stb) begin
        hci_dout <= i_hci_dout;
      end

      if (wr_fire) begin
        case (reg_if.index)
          CONTROL: begin
            o_hci_reset     <= reg_if.wr_data[CTRL_HCI_RESET_BIT];
            o_console_reset <= reg_if.wr_data[CTRL_CONSOLE_RESET_BIT];
          end
          USER_INPUT: begin
            o_jp1_state <= reg_if.wr_data[7:0];
            o_jp2_state <= reg_if.wr_data[15:8];
          end
          HCI_COUNT: o_hci_count <= reg_if.wr_data;
          HCI_ADDR:  o_hci_addr  <= reg_if.wr_data[15:0];
          HCI_OPCODE: begin
            o_hci_opcode     <= reg_if.wr_data[7:0];
            o_hci_opcode_stb <= 1'b1;
          end
          HCI_DATA: begin
            o_hci_din     <= reg_if.wr_data[7:0];
            o_hci_din_stb <= 1'b1;
          end
          HCI_READ_STB: o_hci_host_ready <= reg_if.wr_data[0];
          default: ;
        endcase
        reg_if.invalid <= (reg_if.index > VERSION);
        reg_if.wr_ack  <= 1'b1;
      end else if (rd_fire) begin
        reg_if.invalid <= (reg_if.index > VERSION);
        reg_if.rd_ack  <= 1'b1;
      end
    end
  end

  // Read data travels with rd_ack
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      reg_if.rd_data <= read_word;
    end
  end

endmodule

/* hw/nes_regs_pkg.sv */
/*
  Register map of the console host interface: word indices, bit fields,
  version constants and the HCI data types shared by bank and testbench.
*/
package nes_regs_pkg;

  // Byte address with the two low bits removed
  localparam int REG_INDEX_W = 6;

  typedef enum logic [REG_INDEX_W-1:0] {
    CONTROL      = 6'd0,
    STATUS       = 6'd1,
    USER_INPUT   = 6'd2,
    HCI_COUNT    = 6'd3,
    HCI_ADDR     = 6'd4,
    HCI_OPCODE   = 6'd5,
    HCI_DATA     = 6'd6,
    HCI_READ_STB = 6'd7,
    IMAGE_WIDTH  = 6'd8,
    IMAGE_HEIGHT = 6'd9,
    IMAGE_SIZE   = 6'd10,
    VERSION      = 6'd11
  } reg_index_e;

  // Control register
  localparam int CTRL_HCI_RESET_BIT     = 0;
  localparam int CTRL_CONSOLE_RESET_BIT = 1;

  // Status register
  localparam int STAT_HCI_READY_BIT  = 1;
  localparam int STAT_HCI_STATUS_LSB = 16;

  localparam logic [3:0] VER_MAJOR    = 4'd1;
  localparam logic [7:0] VER_MINOR    = 8'd0;
  localparam logic [3:0] VER_REVISION = 4'd0;
  localparam logic [31:0] VERSION_WORD = {VER_MAJOR, VER_MINOR, VER_REVISION, 16'h0000};

  typedef logic [7:0]  hci_opcode_t;
  typedef logic [7:0]  hci_byte_t;
  typedef logic [15:0] hci_status_t;
  typedef logic [15:0] hci_addr_t;

endpackage

/* hw/reg_access_if.sv */
/*
  One single-word register access between the AXI-Lite slave and the bank.
  Requests are levels held until the matching one-cycle ack.
*/
`timescale 1ns/1ps

interface reg_access_if;
  import axi_lite_pkg::*;
  import nes_regs_pkg::*;

  reg_index_e index;
  logic       wr_rdy;
  axi_data_t  wr_data;
  logic       rd_req;

  logic       wr_ack;
  logic       rd_ack;
  axi_data_t  rd_data;
  // Index past VERSION, flagged together with either ack
  logic       invalid;

  modport slave (output index, wr_rdy, wr_data, rd_req,
                 input  wr_ack, rd_ack, rd_data, invalid);

  modport bank  (input  index, wr_rdy, wr_data, rd_req,
                 output wr_ack, rd_ack, rd_data, invalid);

endinterface

/* run_sim.sh */
#!/bin/sh
# Build and run the register endpoint testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --assert --top-module tb_nes_axi_regs -f all.f \
    --Mdir obj_dir -o sim_tb > "$BUILD_LOG" 2>&1; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so assertion failures reach the testbench summary
if ! ./obj_dir/sim_tb +verilator+error+limit+1000 > "$SIM_LOG" 2>&1; then
  cat "$SIM_LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$SIM_LOG"

if grep -qx "TESTS PASSED" "$SIM_LOG"; then
  exit 0
fi
exit 1
